// File: arp_cache.f
+incdir+hw
hw/arp_entry_pkg.sv
hw/arp_mem_pkg.sv
hw/arp_table_ram.sv
hw/arp_table_arbiter.sv
hw/arp_lookup_engine.sv
hw/arp_learn_engine.sv
hw/arp_aging_walker.sv
hw/arp_cache.sv
dv/arp_cache_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the ARP cache testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
	-f arp_cache.f --top-module arp_cache_tb -Mdir obj_dir

./obj_dir/Varp_cache_tb > sim.log
cat sim.log

if grep -q "^NO ERRORS$" sim.log; then
	echo "Simulation passed"
else
	echo "Simulation failed, see sim.log"
	exit 1
fi

// File: dv/arp_cache_tb.sv
`timescale 1ns/1ps
`include "arp_cache_defines.svh"

module arp_cache_tb;
	import arp_entry_pkg::*;

	localparam int WAYS        = `ARP_NUM_WAYS;
	localparam int ROWS        = `ARP_LINES_PER_WAY * `ARP_NUM_WAYS;
	localparam int LOOKUP_LAT  = WAYS + 2;
	localparam int LEARN_DELAY = 3 * WAYS + 4;
	localparam int PASS_BOUND  = 3 * ROWS;
	// Whole run needs a few thousand cycles at most
	localparam int RUN_LIMIT   = 20000;

	logic                     clk;
	logic                     rst_n;
	logic                     lookup_en;
	logic [31:0]              lookup_ip;
	logic                     lookup_ready;
	logic                     lookup_done;
	logic                     lookup_hit;
	logic [47:0]              lookup_mac;
	logic                     learn_en;
	logic [31:0]              learn_ip;
	logic [47:0]              learn_mac;
	logic                     learn_drop;
	logic                     aging_tick;
	logic [`ARP_AGE_BITS-1:0] max_age;

	int          errors = 0;
	int          cycles = 0;
	int          lk_cnt;
	logic [15:0] lfsr_state;
	// Reference copy of the table, line * ways + way
	arp_entry_t  model_tab [ROWS];
	logic        exp_hit;
	logic [47:0] exp_mac;
	logic        second_learn;
	logic        drop_exp;
	logic [31:0] learned [$];

	arp_cache u_arp_cache (
		.clk, .rst_n, .lookup_en, .lookup_ip, .lookup_ready, .lookup_done,
		.lookup_hit, .lookup_mac, .learn_en, .learn_ip, .learn_mac, .learn_drop,
		.aging_tick, .max_age
	);

	initial clk = 1'b0;
	always #5 clk = ~clk;

	//////////////////////////////////////////////////////////////////////
	// Cycle tracking for the checks

	always @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			lk_cnt   <= 0;
			drop_exp <= 1'b0;
		end else begin
			// Busy learn engine flags the second strobe next cycle
			drop_exp <= learn_en && second_learn;
			// Cycles since the lookup was accepted
			if (lookup_done) begin
				lk_cnt <= 0;
			end else if (lookup_en && lookup_ready) begin
				lk_cnt <= 1;
			end else if (lk_cnt != 0) begin
				lk_cnt <= lk_cnt + 1;
			end
		end
	end

	a_done_latency: assert property (
		@(posedge clk) disable iff (!rst_n) lookup_done |-> lk_cnt == LOOKUP_LAT
	) else begin
		errors++;
		$display("Mismatch at %0t: lookup_done latency expected %0d got %0d",
			$time, LOOKUP_LAT, $sampled(lk_cnt));
	end

	a_done_missing: assert property (
		@(posedge clk) disable iff (!rst_n) (lk_cnt == LOOKUP_LAT) |-> lookup_done
	) else begin
		errors++;
		$display("Mismatch at %0t: lookup_done expected 1 got 0", $time);
	end

	// Busy from the cycle after acceptance through done, ready otherwise
	a_ready: assert property (
		@(posedge clk) disable iff (!rst_n) lookup_ready == (lk_cnt == 0)
	) else begin
		errors++;
		$display("Mismatch at %0t: lookup_ready expected %0b got %0b",
			$time, $sampled(lk_cnt) == 0, $sampled(lookup_ready));
	end

	a_hit: assert property (
		@(posedge clk) disable iff (!rst_n) lookup_done |-> lookup_hit == exp_hit
	) else begin
		errors++;
		$display("Mismatch at %0t: lookup_hit expected %0b got %0b",
			$time, $sampled(exp_hit), $sampled(lookup_hit));
	end

	a_mac: assert property (
		@(posedge clk) disable iff (!rst_n) lookup_done |-> lookup_mac == exp_mac
	) else begin
		errors++;
		$display("Mismatch at %0t: lookup_mac expected %h got %h",
			$time, $sampled(exp_mac), $sampled(lookup_mac));
	end

	a_drop: assert property (
		@(posedge clk) disable iff (!rst_n) learn_drop == drop_exp
	) else begin
		errors++;
		$display("Mismatch at %0t: learn_drop expected %0b got %0b",
			$time, $sampled(drop_exp), $sampled(learn_drop));
	end

	//////////////////////////////////////////////////////////////////////
	// Random source and reference model

	// x^16 + x^14 + x^13 + x^11
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		logic fb;
		fb = s[15] ^ s[13] ^ s[12] ^ s[10];
		return {s[14:0], fb};
	endfunction

	// One step per bit taken
	function automatic logic [63:0] take_bits(input int nbits);
		logic [63:0] v;
		v = '0;
		for (int i = 0; i < nbits; i++) begin
			lfsr_state = lfsr_step(lfsr_state);
			v = {v[62:0], lfsr_state[0]};
		end
		return v;
	endfunction

	// Byte sum folded with the low half, keep the line bits
	function automatic int line_of(input logic [31:0] ip);
		logic [15:0] sum;
		logic [15:0] folded;
		sum = 16'(ip[7:0]) + 16'(ip[15:8]) + 16'(ip[23:16]) + 16'(ip[31:24]);
		folded = sum ^ ip[15:0];
		return int'(folded) % `ARP_LINES_PER_WAY;
	endfunction

	function automatic void model_learn(input logic [31:0] ip, input logic [47:0] mac);
		int                       base;
		int                       target;
		logic [`ARP_AGE_BITS-1:0] oldest;
		base = line_of(ip) * WAYS;
		target = -1;
		// Same IP first
		for (int i = 0; i < WAYS; i++) begin
			if (target < 0 && model_tab[base+i].valid && model_tab[base+i].ip == ip) begin
				target = i;
			end
		end
		// Then the lowest invalid way
		for (int i = 0; i < WAYS; i++) begin
			if (target < 0 && !model_tab[base+i].valid) begin
				target = i;
			end
		end
		// Full line, oldest goes, ties to the lower way
		if (target < 0) begin
			target = 0;
			oldest = model_tab[base].age;
			for (int i = 1; i < WAYS; i++) begin
				if (model_tab[base+i].age > oldest) begin
					target = i;
					oldest = model_tab[base+i].age;
				end
			end
		end
		model_tab[base+target].valid = 1'b1;
		model_tab[base+target].age   = '0;
		model_tab[base+target].ip    = ip;
		model_tab[base+target].mac   = mac;
	endfunction

	function automatic void model_age(input logic [`ARP_AGE_BITS-1:0] limit);
		for (int i = 0; i < ROWS; i++) begin
			if (model_tab[i].valid) begin
				if (model_tab[i].age >= limit) begin
					model_tab[i].valid = 1'b0;
				end else begin
					model_tab[i].age = model_tab[i].age + 1'b1;
				end
			end
		end
	endfunction

	function automatic void model_lookup(input logic [31:0] ip, output logic hit,
		output logic [47:0] mac);
		int base;
		base = line_of(ip) * WAYS;
		hit = 1'b0;
		mac = '1;
		for (int i = 0; i < WAYS; i++) begin
			if (!hit && model_tab[base+i].valid && model_tab[base+i].ip == ip) begin
				hit = 1'b1;
				mac = model_tab[base+i].mac;
			end
		end
	endfunction

	// Random IP landing on the given line
	function automatic logic [31:0] ip_on_line(input int line);
		logic [31:0] ip;
		ip = 32'(take_bits(32));
		while (line_of(ip) != line) begin
			ip = 32'(take_bits(32));
		end
		return ip;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Stimulus tasks

	task automatic run_lookup(input logic [31:0] ip);
		logic        hit;
		logic [47:0] mac;
		int          guard;
		guard = 0;
		@(negedge clk);
		while (!lookup_ready && guard < 100) begin
			guard++;
			@(negedge clk);
		end
		if (!lookup_ready) begin
			errors++;
			$display("lookup_ready stayed low for 100 cycles at %0t", $time);
		end
		model_lookup(ip, hit, mac);
		@(posedge clk);
		lookup_en <= 1'b1;
		lookup_ip <= ip;
		exp_hit   <= hit;
		exp_mac   <= mac;
		@(posedge clk);
		lookup_en <= 1'b0;
		// Wait for the done pulse
		guard = 0;
		@(negedge clk);
		while (!lookup_done && guard < 2 * LOOKUP_LAT) begin
			guard++;
			@(negedge clk);
		end
		if (!lookup_done) begin
			errors++;
			$display("Lookup of %h never raised lookup_done", ip);
		end
	endtask

	task automatic issue_learn(input logic [31:0] ip, input logic [47:0] mac);
		@(posedge clk);
		learn_en  <= 1'b1;
		learn_ip  <= ip;
		learn_mac <= mac;
		@(posedge clk);
		learn_en <= 1'b0;
		model_learn(ip, mac);
	endtask

	task automatic learn_and_settle(input logic [31:0] ip, input logic [47:0] mac);
		issue_learn(ip, mac);
		repeat (LEARN_DELAY) @(posedge clk);
	endtask

	task automatic start_aging(input logic [`ARP_AGE_BITS-1:0] limit);
		@(posedge clk);
		max_age    <= limit;
		aging_tick <= 1'b1;
		@(posedge clk);
		aging_tick <= 1'b0;
		model_age(limit);
	endtask

	//////////////////////////////////////////////////////////////////////
	// Test sequence

	initial begin
		logic [31:0] ip_a;
		logic [31:0] ip_b;
		logic [31:0] ip_p;
		logic [31:0] ip_r;
		logic [31:0] line_ips [5];
		logic [47:0] mac_a;
		logic [47:0] mac_r;
		int          line;
		lfsr_state   = 16'd31197;
		rst_n        = 1'b0;
		lookup_en    = 1'b0;
		lookup_ip    = '0;
		learn_en     = 1'b0;
		learn_ip     = '0;
		learn_mac    = '0;
		aging_tick   = 1'b0;
		max_age      = 15'd100;
		second_learn = 1'b0;
		exp_hit      = 1'b0;
		exp_mac      = '0;
		for (int i = 0; i < ROWS; i++) begin
			model_tab[i] = '0;
		end
		repeat (2) @(posedge clk);
		rst_n <= 1'b1;
		// Clearing pass
		repeat (PASS_BOUND) @(posedge clk);

		// Never learned, miss with broadcast MAC
		run_lookup(32'(take_bits(32)));

		// Learn, then refresh with a new MAC
		ip_a = 32'(take_bits(32));
		learned.push_back(ip_a);
		learn_and_settle(ip_a, 48'(take_bits(48)));
		run_lookup(ip_a);
		learn_and_settle(ip_a, 48'(take_bits(48)));
		run_lookup(ip_a);

		// Five IPs on one empty line, first one evicted
		line = 0;
		while (model_tab[line*WAYS].valid && line < `ARP_LINES_PER_WAY - 1) begin
			line++;
		end
		for (int i = 0; i < 5; i++) begin
			line_ips[i] = ip_on_line(line);
			learned.push_back(line_ips[i]);
			learn_and_settle(line_ips[i], 48'(take_bits(48)));
		end
		for (int i = 0; i < 5; i++) begin
			run_lookup(line_ips[i]);
		end

		// Back-to-back learns, second one dropped
		ip_a = 32'(take_bits(32));
		ip_b = 32'(take_bits(32));
		learned.push_back(ip_a);
		learned.push_back(ip_b);
		mac_a = 48'(take_bits(48));
		@(posedge clk);
		learn_en  <= 1'b1;
		learn_ip  <= ip_a;
		learn_mac <= mac_a;
		@(posedge clk);
		learn_ip     <= ip_b;
		learn_mac    <= 48'(take_bits(48));
		second_learn <= 1'b1;
		@(posedge clk);
		learn_en     <= 1'b0;
		second_learn <= 1'b0;
		model_learn(ip_a, mac_a);
		repeat (LEARN_DELAY) @(posedge clk);
		run_lookup(ip_b);
		run_lookup(ip_a);

		// Three passes at max_age 2, one entry refreshed between passes
		ip_p  = 32'(take_bits(32));
		ip_r  = 32'(take_bits(32));
		mac_r = 48'(take_bits(48));
		learned.push_back(ip_p);
		learned.push_back(ip_r);
		learn_and_settle(ip_p, 48'(take_bits(48)));
		learn_and_settle(ip_r, mac_r);
		for (int pass = 0; pass < 3; pass++) begin
			start_aging(15'd2);
			repeat (PASS_BOUND) @(posedge clk);
			if (pass < 2) begin
				learn_and_settle(ip_r, mac_r);
			end
		end
		run_lookup(ip_p);
		run_lookup(ip_r);

		// Lookups racing an aging pass and a queued learn
		// Line with its top way free, so the late learn evicts nothing
		ip_a = 32'(take_bits(32));
		while (model_tab[line_of(ip_a)*WAYS + WAYS - 1].valid) begin
			ip_a = 32'(take_bits(32));
		end
		start_aging(15'd100);
		run_lookup(ip_r);
		issue_learn(ip_a, 48'(take_bits(48)));
		foreach (learned[k]) begin
			run_lookup(learned[k]);
		end
		run_lookup(32'(take_bits(32)));
		repeat (PASS_BOUND + LEARN_DELAY) @(posedge clk);
		run_lookup(ip_a);
		run_lookup(ip_r);

		repeat (4) @(posedge clk);
		$display("Checks done, %0d errors", errors);
		if (errors == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

	// Run guard
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= RUN_LIMIT) begin
			errors++;
			$display("Timeout, test did not reach its end within %0d cycles", RUN_LIMIT);
			$display("Checks done, %0d errors", errors);
			$display("ERRORS FOUND");
			$finish;
		end
	end

endmodule

// File: hw/arp_cache.sv
`timescale 1ns/1ps
`include "arp_cache_defines.svh"

module arp_cache (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     lookup_en,
	input  logic [31:0]              lookup_ip,
	output logic                     lookup_ready,
	output logic                     lookup_done,
	output logic                     lookup_hit,
	output logic [47:0]              lookup_mac,
	input  logic                     learn_en,
	input  logic [31:0]              learn_ip,
	input  logic [47:0]              learn_mac,
	output logic                     learn_drop,
	input  logic                     aging_tick,
	input  logic [`ARP_AGE_BITS-1:0] max_age
);
	import arp_mem_pkg::*;

	// Engine side of the arbiter
	table_req_t lookup_req, learn_req, aging_req;
	table_rsp_t lookup_rsp, learn_rsp, aging_rsp;
	logic       lookup_grant, learn_grant, aging_grant;
	logic       learn_lock_req, aging_lock_req;
	logic       learn_lock_own, aging_lock_own;
	// Memory side
	table_req_t mem_req;
	table_rsp_t mem_rsp;

	arp_lookup_engine u_lookup (
		.clk, .rst_n, .lookup_en, .lookup_ip, .lookup_ready, .lookup_done,
		.lookup_hit, .lookup_mac,
		.req(lookup_req), .grant(lookup_grant), .rsp(lookup_rsp)
	);

	arp_learn_engine u_learn (
		.clk, .rst_n, .learn_en, .learn_ip, .learn_mac, .learn_drop,
		.req(learn_req), .grant(learn_grant), .rsp(learn_rsp),
		.lock_req(learn_lock_req), .lock_own(learn_lock_own)
	);

	arp_aging_walker u_aging (
		.clk, .rst_n, .aging_tick, .max_age,
		.req(aging_req), .grant(aging_grant), .rsp(aging_rsp),
		.lock_req(aging_lock_req), .lock_own(aging_lock_own)
	);

	arp_table_arbiter u_arbiter (
		.clk, .rst_n, .lookup_req, .learn_req, .aging_req,
		.learn_lock_req, .aging_lock_req, .lookup_rsp, .learn_rsp, .aging_rsp,
		.lookup_grant, .learn_grant, .aging_grant, .learn_lock_own, .aging_lock_own,
		.mem_req, .mem_rsp
	);

	arp_table_ram u_ram (.clk, .req(mem_req), .rsp(mem_rsp));

endmodule

// File: hw/arp_aging_walker.sv
`timescale 1ns/1ps
`include "arp_cache_defines.svh"

module arp_aging_walker (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     aging_tick,
	input  logic [`ARP_AGE_BITS-1:0] max_age,
	output arp_mem_pkg::table_req_t  req,
	input  logic                     grant,
	input  arp_mem_pkg::table_rsp_t  rsp,
	output logic                     lock_req,
	input  logic                     lock_own
);
	import arp_entry_pkg::*;

	aging_state_t              state;
	logic [`ARP_ADDR_BITS-1:0] row;
	arp_entry_t                held_q;
	logic                      held_v;
	arp_entry_t                entry_in;
	arp_entry_t                aged;

	// Clearing pass also needs the lock
	assign lock_req = (state != AGING_IDLE);

	// Fresh read data, or the copy kept while waiting on a grant
	assign entry_in = rsp.valid ? rsp.rdata : held_q;

	always_comb begin
		aged = entry_in;
		if (entry_in.valid) begin
			if (entry_in.age >= max_age) begin
				aged.valid = 1'b0;
			end else begin
				aged.age = entry_in.age + 1'b1;
			end
		end
	end

	always_comb begin
		req      = '0;
		req.addr = row;
		case (state)
			AGING_CLEAR: begin
				req.req   = lock_own;
				req.write = 1'b1;
			end
			AGING_READ: req.req = 1'b1;
			AGING_WRITE: begin
				req.req   = rsp.valid || held_v;
				req.write = 1'b1;
				req.wdata = aged;
			end
			default: req.req = 1'b0;
		endcase
	end

	//////////////////////////////////////////////////////////////////////
	// Row walk

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state  <= AGING_CLEAR;
			row    <= '0;
			held_v <= 1'b0;
		end else begin
			if (state == AGING_WRITE && grant) begin
				held_v <= 1'b0;
			end else if (rsp.valid) begin
				held_v <= 1'b1;
			end
			case (state)
				AGING_CLEAR: begin
					if (grant) begin
						row <= row + 1'b1;
						if (row == '1) state <= AGING_IDLE;
					end
				end
				// Ticks mid-pass are dropped
				AGING_IDLE: begin
					if (aging_tick) begin
						state <= AGING_WAIT_LOCK;
						row   <= '0;
					end
				end
				AGING_WAIT_LOCK: if (lock_own) state <= AGING_READ;
				AGING_READ: if (grant) state <= AGING_WRITE;
				AGING_WRITE: begin
					if (grant) begin
						row   <= row + 1'b1;
						state <= (row == '1) ? AGING_IDLE : AGING_READ;
					end
				end
				default: state <= AGING_IDLE;
			endcase
		end
	end

	// Read copy for a delayed write
	always_ff @(posedge clk) begin
		if (rsp.valid) held_q <= rsp.rdata;
	end

	// Source of ticks must respect the post-reset clear
	a_no_tick_in_clear: assert property (
		@(posedge clk) disable iff (!rst_n) (state == AGING_CLEAR) |-> !aging_tick
	) else $error("aging_tick during clearing pass");

endmodule

// File: hw/arp_learn_engine.sv
`timescale 1ns/1ps
`include "arp_cache_defines.svh"

module arp_learn_engine (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    learn_en,
	input  logic [31:0]             learn_ip,
	input  logic [47:0]             learn_mac,
	output logic                    learn_drop,
	output arp_mem_pkg::table_req_t req,
	input  logic                    grant,
	input  arp_mem_pkg::table_rsp_t rsp,
	output logic                    lock_req,
	input  logic                    lock_own
);
	import arp_entry_pkg::*;

	learn_state_t              state;
	logic [31:0]               ip_q;
	logic [47:0]               mac_q;
	logic [`ARP_LINE_BITS-1:0] line_q;
	logic [`ARP_WAY_BITS-1:0]  rd_way;
	logic [`ARP_WAY_BITS-1:0]  rsp_way;
	logic                      all_rsp;
	logic                      match_found;
	logic [`ARP_WAY_BITS-1:0]  match_way;
	logic                      free_found;
	logic [`ARP_WAY_BITS-1:0]  free_way;
	logic [`ARP_WAY_BITS-1:0]  old_way;
	logic [`ARP_AGE_BITS-1:0]  old_age;
	logic [`ARP_WAY_BITS-1:0]  target_way;
	logic [`ARP_WAY_BITS-1:0]  choice_way;

	// Lock held for the whole read-modify-write
	assign lock_req = (state != LEARN_IDLE);

	// Same IP, else lowest free, else oldest
	assign choice_way = match_found ? match_way : (free_found ? free_way : old_way);

	always_comb begin
		req             = '0;
		req.req         = (state == LEARN_READ) || (state == LEARN_WRITE);
		req.write       = (state == LEARN_WRITE);
		req.addr        = {line_q, (state == LEARN_WRITE) ? target_way : rd_way};
		req.wdata.valid = 1'b1;
		req.wdata.ip    = ip_q;
		req.wdata.mac   = mac_q;
	end

	//////////////////////////////////////////////////////////////////////
	// Pending learn FSM

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state       <= LEARN_IDLE;
			learn_drop  <= 1'b0;
			rd_way      <= '0;
			rsp_way     <= '0;
			all_rsp     <= 1'b0;
			match_found <= 1'b0;
			match_way   <= '0;
			free_found  <= 1'b0;
			free_way    <= '0;
			old_way     <= '0;
			old_age     <= '0;
			target_way  <= '0;
		end else begin
			// Busy, the new one is lost
			learn_drop <= learn_en && (state != LEARN_IDLE);
			// Scan each returning way in order
			if (rsp.valid) begin
				rsp_way <= rsp_way + 1'b1;
				all_rsp <= all_rsp || (rsp_way == '1);
				if (rsp.rdata.valid && rsp.rdata.ip == ip_q && !match_found) begin
					match_found <= 1'b1;
					match_way   <= rsp_way;
				end
				if (!rsp.rdata.valid && !free_found) begin
					free_found <= 1'b1;
					free_way   <= rsp_way;
				end
				// Strictly older only, ties stay low
				if (rsp.rdata.age > old_age) begin
					old_way <= rsp_way;
					old_age <= rsp.rdata.age;
				end
			end
			case (state)
				LEARN_IDLE: begin
					if (learn_en) begin
						state       <= LEARN_WAIT_LOCK;
						rd_way      <= '0;
						rsp_way     <= '0;
						all_rsp     <= 1'b0;
						match_found <= 1'b0;
						free_found  <= 1'b0;
						old_way     <= '0;
						old_age     <= '0;
					end
				end
				LEARN_WAIT_LOCK: if (lock_own) state <= LEARN_READ;
				LEARN_READ: begin
					if (grant) begin
						rd_way <= rd_way + 1'b1;
						if (rd_way == '1) state <= LEARN_CHOOSE;
					end
				end
				LEARN_CHOOSE: begin
					if (all_rsp) begin
						target_way <= choice_way;
						state      <= LEARN_WRITE;
					end
				end
				LEARN_WRITE: if (grant) state <= LEARN_IDLE;
				default: state <= LEARN_IDLE;
			endcase
		end
	end

	// Pending entry payload
	always_ff @(posedge clk) begin
		if (state == LEARN_IDLE && learn_en) begin
			ip_q   <= learn_ip;
			mac_q  <= learn_mac;
			line_q <= arp_hash(learn_ip);
		end
	end

endmodule

// File: hw/arp_lookup_engine.sv
`timescale 1ns/1ps
`include "arp_cache_defines.svh"

module arp_lookup_engine (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    lookup_en,
	input  logic [31:0]             lookup_ip,
	output logic                    lookup_ready,
	output logic                    lookup_done,
	output logic                    lookup_hit,
	output logic [47:0]             lookup_mac,
	output arp_mem_pkg::table_req_t req,
	input  logic                    grant,
	input  arp_mem_pkg::table_rsp_t rsp
);
	import arp_entry_pkg::*;

	lookup_state_t             state;
	logic [31:0]               ip_q;
	logic [`ARP_LINE_BITS-1:0] line_q;
	logic [`ARP_WAY_BITS-1:0]  rd_way;
	logic [`ARP_WAY_BITS-1:0]  rsp_way;
	logic                      found_q;
	logic [47:0]               mac_q;
	logic                      rsp_match;
	logic                      last_rsp;

	// Low through the done cycle, back up the cycle after
	assign lookup_ready = (state == LOOKUP_IDLE) && !lookup_done;

	assign rsp_match = rsp.valid && rsp.rdata.valid && (rsp.rdata.ip == ip_q);
	assign last_rsp  = rsp.valid && (rsp_way == '1) && (state == LOOKUP_FINISH);

	// One read per way, back to back
	always_comb begin
		req      = '0;
		req.req  = (state == LOOKUP_READ);
		req.addr = {line_q, rd_way};
	end

	//////////////////////////////////////////////////////////////////////
	// Walk control

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state       <= LOOKUP_IDLE;
			rd_way      <= '0;
			rsp_way     <= '0;
			found_q     <= 1'b0;
			lookup_done <= 1'b0;
			lookup_hit  <= 1'b0;
		end else begin
			lookup_done <= 1'b0;
			lookup_hit  <= 1'b0;
			// Count returning ways, first match wins
			if (rsp.valid) begin
				rsp_way <= rsp_way + 1'b1;
			end
			if (rsp_match && !found_q) begin
				found_q <= 1'b1;
			end
			case (state)
				LOOKUP_IDLE: begin
					if (lookup_en && lookup_ready) begin
						state   <= LOOKUP_READ;
						rd_way  <= '0;
						rsp_way <= '0;
						found_q <= 1'b0;
					end
				end
				LOOKUP_READ: begin
					if (grant) begin
						rd_way <= rd_way + 1'b1;
						if (rd_way == '1) begin
							state <= LOOKUP_FINISH;
						end
					end
				end
				LOOKUP_FINISH: begin
					// Last way back, report
					if (last_rsp) begin
						lookup_done <= 1'b1;
						lookup_hit  <= found_q || rsp_match;
						state       <= LOOKUP_IDLE;
					end
				end
				default: state <= LOOKUP_IDLE;
			endcase
		end
	end

	// Address and MAC payload
	always_ff @(posedge clk) begin
		if (state == LOOKUP_IDLE && lookup_en && lookup_ready) begin
			ip_q   <= lookup_ip;
			line_q <= arp_hash(lookup_ip);
		end
		if (rsp_match && !found_q) begin
			mac_q <= rsp.rdata.mac;
		end
		// Broadcast MAC on a miss
		if (last_rsp) begin
			lookup_mac <= found_q ? mac_q : (rsp_match ? rsp.rdata.mac : '1);
		end
	end

endmodule

// File: hw/arp_table_arbiter.sv
`timescale 1ns/1ps

module arp_table_arbiter (
	input  logic                    clk,
	input  logic                    rst_n,
	input  arp_mem_pkg::table_req_t lookup_req,
	input  arp_mem_pkg::table_req_t learn_req,
	input  arp_mem_pkg::table_req_t aging_req,
	input  logic                    learn_lock_req,
	input  logic                    aging_lock_req,
	output arp_mem_pkg::table_rsp_t lookup_rsp,
	output arp_mem_pkg::table_rsp_t learn_rsp,
	output arp_mem_pkg::table_rsp_t aging_rsp,
	output logic                    lookup_grant,
	output logic                    learn_grant,
	output logic                    aging_grant,
	output logic                    learn_lock_own,
	output logic                    aging_lock_own,
	output arp_mem_pkg::table_req_t mem_req,
	input  arp_mem_pkg::table_rsp_t mem_rsp
);
	import arp_mem_pkg::*;

	requester_t last_q;

	// Lookup always wins, the others only under their own lock
	assign lookup_grant = lookup_req.req;
	assign learn_grant  = learn_req.req && learn_lock_own && !lookup_req.req;
	assign aging_grant  = aging_req.req && aging_lock_own && !lookup_req.req && !learn_grant;

	always_comb begin
		mem_req = '0;
		if (lookup_grant) begin
			mem_req = lookup_req;
		end else if (learn_grant) begin
			mem_req = learn_req;
		end else if (aging_grant) begin
			mem_req = aging_req;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Response routing and lock ownership

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			last_q         <= REQ_LOOKUP;
			learn_lock_own <= 1'b0;
			aging_lock_own <= 1'b0;
		end else begin
			if (lookup_grant) begin
				last_q <= REQ_LOOKUP;
			end else if (learn_grant) begin
				last_q <= REQ_LEARN;
			end else if (aging_grant) begin
				last_q <= REQ_AGING;
			end
			// Owner keeps it until lock_req drops, learn before aging
			if (learn_lock_own) begin
				learn_lock_own <= learn_lock_req;
			end else if (aging_lock_own) begin
				aging_lock_own <= aging_lock_req;
			end else if (learn_lock_req) begin
				learn_lock_own <= 1'b1;
			end else if (aging_lock_req) begin
				aging_lock_own <= 1'b1;
			end
		end
	end

	// Read data goes to everyone, valid only to the last grantee
	always_comb begin
		lookup_rsp       = mem_rsp;
		learn_rsp        = mem_rsp;
		aging_rsp        = mem_rsp;
		lookup_rsp.valid = mem_rsp.valid && (last_q == REQ_LOOKUP);
		learn_rsp.valid  = mem_rsp.valid && (last_q == REQ_LEARN);
		aging_rsp.valid  = mem_rsp.valid && (last_q == REQ_AGING);
	end

	a_grant_onehot: assert property (
		@(posedge clk) disable iff (!rst_n) $onehot0({lookup_grant, learn_grant, aging_grant})
	) else $error("more than one table grant");

	// Writes come only from the lock holder
	a_write_owner: assert property (
		@(posedge clk) disable iff (!rst_n)
			(learn_req.req && learn_req.write |-> learn_lock_own) and
			(aging_req.req && aging_req.write |-> aging_lock_own)
	) else $error("table write requested without lock");

endmodule

// File: hw/arp_table_ram.sv
`timescale 1ns/1ps
`include "arp_cache_defines.svh"

module arp_table_ram (
	input  logic                    clk,
	input  arp_mem_pkg::table_req_t req,
	output arp_mem_pkg::table_rsp_t rsp
);
	import arp_entry_pkg::*;

	localparam int ROWS = `ARP_LINES_PER_WAY * `ARP_NUM_WAYS;

	// Row storage, 96 bits wide
	arp_entry_t table_mem [ROWS];

	//////////////////////////////////////////////////////////////////////
	// Write port

	always_ff @(posedge clk) begin
		if (req.req && req.write) begin
			table_mem[req.addr] <= req.wdata;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Registered read

	always_ff @(posedge clk) begin
		// Valid only for the cycle after a read grant
		rsp.valid <= req.req && !req.write;
		if (req.req && !req.write) begin
			rsp.rdata <= table_mem[req.addr];
		end
	end

	// Arbiter must never pass an unresolved address
	a_addr_known: assert property (
		@(posedge clk) req.req |-> !$isunknown(req.addr)
	) else $error("table address unknown while req is high");

endmodule

// File: hw/arp_mem_pkg.sv
`include "arp_cache_defines.svh"

package arp_mem_pkg;

	// Request from one engine toward the table
	typedef struct packed {
		logic                       req;
		logic                       write;
		logic [`ARP_ADDR_BITS-1:0]  addr;
		arp_entry_pkg::arp_entry_t  wdata;
	} table_req_t;

	// Read data, one cycle after the grant
	typedef struct packed {
		logic                       valid;
		arp_entry_pkg::arp_entry_t  rdata;
	} table_rsp_t;

	// Who was granted last, for response routing
	typedef enum logic [1:0] {
		REQ_LOOKUP,
		REQ_LEARN,
		REQ_AGING
	} requester_t;

endpackage

// File: hw/arp_entry_pkg.sv
`include "arp_cache_defines.svh"

package arp_entry_pkg;

	// One table row, 1 + 15 + 32 + 48 bits
	typedef struct packed {
		logic                     valid;
		logic [`ARP_AGE_BITS-1:0] age;
		logic [31:0]              ip;
		logic [47:0]              mac;
	} arp_entry_t;

	// Lookup walk
	typedef enum logic [1:0] {
		LOOKUP_IDLE,
		LOOKUP_READ,
		LOOKUP_FINISH
	} lookup_state_t;

	// Learn insert or refresh
	typedef enum logic [2:0] {
		LEARN_IDLE,
		LEARN_WAIT_LOCK,
		LEARN_READ,
		LEARN_CHOOSE,
		LEARN_WRITE
	} learn_state_t;

	// Aging walk, clearing pass first out of reset
	typedef enum logic [2:0] {
		AGING_CLEAR,
		AGING_IDLE,
		AGING_WAIT_LOCK,
		AGING_READ,
		AGING_WRITE
	} aging_state_t;

	// Byte sum folded with the low half of the address
	function automatic logic [`ARP_LINE_BITS-1:0] arp_hash(input logic [31:0] ip);
		logic [15:0] sum;
		logic [15:0] mixed;
		sum = ip[7:0] + ip[15:8] + ip[23:16] + ip[31:24];
		mixed = sum ^ ip[15:0];
		return mixed[`ARP_LINE_BITS-1:0];
	endfunction

endpackage

// File: hw/arp_cache_defines.svh
`ifndef ARP_CACHE_DEFINES_SVH
`define ARP_CACHE_DEFINES_SVH

// Table geometry
`define ARP_LINES_PER_WAY 16
`define ARP_NUM_WAYS 4

// Line select and way select widths
`define ARP_LINE_BITS ($clog2(`ARP_LINES_PER_WAY))
`define ARP_WAY_BITS ($clog2(`ARP_NUM_WAYS))

// Entry address, line in the high bits and way in the low bits
`define ARP_ADDR_BITS (`ARP_LINE_BITS + `ARP_WAY_BITS)

// Age counter pads an entry out to 96 bits
`define ARP_AGE_BITS 15

`endif
